// ==== hw/blimp_pkg.sv ====
// Blimp core shared definitions
// Widths, operation classes, channel payload structs and the
// instruction field helpers used by every unit of the core
package blimp_pkg;

  // ---------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------
  parameter int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     addr_t;
  typedef logic [4:0]      areg_t;

  // Upper bounds, modules use only the low bits they need
  parameter int seq_max_bits  = 6;
  parameter int preg_max_bits = 7;

  typedef enum logic [1:0] {
    op_add  = 2'd0,
    op_addi = 2'd1,
    op_mul  = 2'd2
  } op_e;

  // ---------------------------------------------------------------------
  // Channel payloads
  // ---------------------------------------------------------------------
  typedef struct packed { addr_t addr; } mem_req_t;
  typedef struct packed { word_t inst; } mem_resp_t;
  typedef struct packed { addr_t pc; word_t inst; } f2d_t;

  typedef struct packed {
    logic [seq_max_bits-1:0]  seq;
    addr_t                    pc;
    op_e                      op;
    word_t                    op_a;
    word_t                    op_b;
    logic [preg_max_bits-1:0] pdst;
    // Previous mapping of waddr, freed at commit
    logic [preg_max_bits-1:0] pold;
    logic                     wen;
    areg_t                    waddr;
  } d2x_t;

  typedef struct packed {
    logic [seq_max_bits-1:0]  seq;
    logic [preg_max_bits-1:0] pdst;
    logic                     wen;
    areg_t                    waddr;
    word_t                    wdata;
  } x2w_t;

  typedef struct packed {
    logic                     val;
    logic [seq_max_bits-1:0]  seq;
    logic [preg_max_bits-1:0] pdst;
    word_t                    wdata;
  } complete_t;

  typedef struct packed {
    logic                     val;
    logic [seq_max_bits-1:0]  seq;
    addr_t                    pc;
    areg_t                    waddr;
    word_t                    wdata;
    logic                     wen;
    logic [preg_max_bits-1:0] pold;
  } commit_t;

  typedef struct packed {
    addr_t pc;
    areg_t waddr;
    word_t wdata;
    logic  wen;
  } trace_t;

  // ---------------------------------------------------------------------
  // Instruction fields
  // ---------------------------------------------------------------------
  // Only add, addi and mul exist, so opcode and funct7[0] suffice
  function automatic op_e decode_op(word_t inst);
    if (inst[6:0] == 7'b0010011) return op_addi;
    if (inst[25]) return op_mul;
    return op_add;
  endfunction

  // I-type immediate, sign extended
  function automatic word_t imm_i(word_t inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

endpackage

// ==== hw/fetch_unit.sv ====
// Blimp fetch unit
// Streams sequential PCs to instruction memory with one request in
// flight and buffers each response, paired with its PC, toward decode
`timescale 1ns/100ps

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  output blimp_pkg::mem_req_t  imem_req,
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  input  blimp_pkg::mem_resp_t imem_resp,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  output blimp_pkg::f2d_t      f2d,
  output logic                 f2d_val,
  input  logic                 f2d_rdy
);
  import blimp_pkg::*;

  addr_t pc;
  addr_t req_pc;
  logic  started;
  logic  in_flight;
  logic  req_fire;
  logic  resp_fire;

  // No request until one cycle after reset
  assign imem_req_val  = started & ~in_flight;
  assign imem_req.addr = pc;
  assign req_fire      = imem_req_val & imem_req_rdy;

  // Take a response only when the buffer is free or draining
  assign imem_resp_rdy = ~f2d_val | f2d_rdy;
  assign resp_fire     = imem_resp_val & imem_resp_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= '0;
      req_pc    <= '0;
      started   <= 1'b0;
      in_flight <= 1'b0;
      f2d_val   <= 1'b0;
      f2d       <= '0;
    end else begin
      started <= 1'b1;
      // Advance pc per accepted request, remember its address
      if (req_fire) begin
        pc        <= pc + 32'd4;
        req_pc    <= pc;
        in_flight <= 1'b1;
      end else if (resp_fire) begin
        in_flight <= 1'b0;
      end
      // One-entry buffer toward decode
      if (resp_fire) begin
        f2d_val  <= 1'b1;
        f2d.pc   <= req_pc;
        f2d.inst <= imem_resp.inst;
      end else if (f2d_rdy) begin
        f2d_val <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/decode_issue_unit.sv ====
// Blimp decode-issue unit
// Renames each instruction onto physical registers, tracks ready bits
// and the physical register file, and issues in order to the ALU or
// multiplier pipe once operands, a free register and a ROB slot exist
`timescale 1ns/100ps

module decode_issue_unit #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_num_phys_regs = 40
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blimp_pkg::f2d_t      f2d,
  input  logic                 f2d_val,
  output logic                 f2d_rdy,
  output blimp_pkg::d2x_t      d2x_alu,
  output logic                 d2x_alu_val,
  input  logic                 alu_rdy,
  output blimp_pkg::d2x_t      d2x_mul,
  output logic                 d2x_mul_val,
  input  logic                 mul_rdy,
  input  blimp_pkg::complete_t complete,
  input  blimp_pkg::commit_t   commit
);
  import blimp_pkg::*;

  localparam int pw = $clog2(p_num_phys_regs);

  // Rename state and register file
  logic [pw-1:0]              rename_tbl [32];
  logic [p_num_phys_regs-1:0] free_list;
  logic [p_num_phys_regs-1:0] ready;
  word_t                      prf [p_num_phys_regs];
  logic [p_seq_num_bits-1:0]  seq_next;
  logic [p_seq_num_bits:0]    in_flight;

  op_e           op;
  areg_t         rs1, rs2, rd;
  logic [pw-1:0] prs1, prs2, pold, pnew, cpl_pdst, cmt_pold;
  logic          byp1, byp2, src1_ok, src2_ok;
  logic          need_preg, have_preg, rob_ok, pipe_ok, go, issue;
  word_t         rs1_val, rs2_val;
  d2x_t          d2x;

  assign op       = decode_op(f2d.inst);
  assign rd       = f2d.inst[11:7];
  assign rs1      = f2d.inst[19:15];
  assign rs2      = f2d.inst[24:20];
  assign prs1     = rename_tbl[rs1];
  assign prs2     = rename_tbl[rs2];
  assign pold     = rename_tbl[rd];
  assign cpl_pdst = complete.pdst[pw-1:0];
  assign cmt_pold = commit.pold[pw-1:0];

  // Lowest free physical register
  always_comb begin
    pnew = '0;
    for (int i = p_num_phys_regs - 1; i >= 0; i--) begin
      if (free_list[i]) pnew = pw'(i);
    end
  end
  assign have_preg = |free_list;

  // Same-cycle completion bypass
  assign byp1    = complete.val && (cpl_pdst == prs1);
  assign byp2    = complete.val && (cpl_pdst == prs2);
  assign src1_ok = ready[prs1] | byp1;
  assign src2_ok = ready[prs2] | byp2 | (op == op_addi);
  assign rs1_val = byp1 ? complete.wdata : prf[prs1];
  assign rs2_val = byp2 ? complete.wdata : prf[prs2];

  // x0 stays pinned to physical 0, so x0 writes carry no destination
  assign need_preg = (rd != 5'd0);
  // Top bit set means every ROB slot is taken
  assign rob_ok    = ~in_flight[p_seq_num_bits];
  assign pipe_ok   = (op == op_mul) ? mul_rdy : alu_rdy;
  assign go        = src1_ok & src2_ok & (have_preg | ~need_preg) & rob_ok & pipe_ok;
  assign f2d_rdy   = go;
  assign issue     = f2d_val & go;

  always_comb begin
    d2x       = '0;
    d2x.seq   = seq_max_bits'(seq_next);
    d2x.pc    = f2d.pc;
    d2x.op    = op;
    d2x.op_a  = rs1_val;
    d2x.op_b  = (op == op_addi) ? imm_i(f2d.inst) : rs2_val;
    d2x.pdst  = need_preg ? preg_max_bits'(pnew) : '0;
    d2x.pold  = preg_max_bits'(pold);
    d2x.wen   = need_preg;
    d2x.waddr = rd;
  end

  // Same payload to both pipes, valid steers it
  assign d2x_alu     = d2x;
  assign d2x_mul     = d2x;
  assign d2x_alu_val = issue & (op != op_mul);
  assign d2x_mul_val = issue & (op == op_mul);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map, registers above 31 free, all values zero
      for (int i = 0; i < 32; i++) begin
        rename_tbl[i] <= pw'(i);
      end
      for (int i = 0; i < p_num_phys_regs; i++) begin
        free_list[i] <= (i >= 32);
        ready[i]     <= 1'b1;
        prf[i]       <= '0;
      end
      seq_next  <= '0;
      in_flight <= '0;
    end else begin
      if (complete.val) begin
        prf[cpl_pdst]   <= complete.wdata;
        ready[cpl_pdst] <= 1'b1;
      end
      // Old mapping returns to the pool at commit
      if (commit.val && commit.wen) free_list[cmt_pold] <= 1'b1;
      if (issue) begin
        seq_next <= seq_next + 1'b1;
        if (need_preg) begin
          rename_tbl[rd]  <= pnew;
          free_list[pnew] <= 1'b0;
          ready[pnew]     <= 1'b0;
        end
      end
      case ({issue, commit.val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Completions land only on registers still waiting for a value
  a_cpl_pending: assert property (@(posedge clk) disable iff (!rst_n)
    complete.val |-> !ready[cpl_pdst]);

  // An old mapping freed at commit is not already in the pool
  a_no_double_free: assert property (@(posedge clk) disable iff (!rst_n)
    (commit.val && commit.wen) |-> !free_list[cmt_pold]);

endmodule

// ==== hw/alu_unit.sv ====
// Blimp ALU pipe
// Single registered stage adding op_a and op_b, with addi already
// carrying its immediate in op_b
`timescale 1ns/100ps

module alu_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  blimp_pkg::d2x_t d2x_alu,
  input  logic            d2x_alu_val,
  output logic            d2x_alu_rdy,
  output blimp_pkg::x2w_t x2w_alu,
  output logic            x2w_alu_val,
  input  logic            x2w_rdy
);
  import blimp_pkg::*;

  // Accept when empty or the result leaves this cycle
  assign d2x_alu_rdy = ~x2w_alu_val | x2w_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x2w_alu_val <= 1'b0;
      x2w_alu     <= '0;
    end else if (d2x_alu_val && d2x_alu_rdy) begin
      x2w_alu_val   <= 1'b1;
      x2w_alu.seq   <= d2x_alu.seq;
      x2w_alu.pdst  <= d2x_alu.pdst;
      x2w_alu.wen   <= d2x_alu.wen;
      x2w_alu.waddr <= d2x_alu.waddr;
      x2w_alu.wdata <= d2x_alu.op_a + d2x_alu.op_b;
    end else if (x2w_rdy) begin
      x2w_alu_val <= 1'b0;
    end
  end

endmodule

// ==== hw/pipelined_multiplier.sv ====
// Blimp multiplier pipe
// Product computed on entry, then carried down a shift chain of
// p_mul_stages stages that freezes as a whole under back-pressure
`timescale 1ns/100ps

module pipelined_multiplier #(
  parameter int p_mul_stages = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  blimp_pkg::d2x_t d2x_mul,
  input  logic            d2x_mul_val,
  output logic            d2x_mul_rdy,
  output blimp_pkg::x2w_t x2w_mul,
  output logic            x2w_mul_val,
  input  logic            x2w_rdy
);
  import blimp_pkg::*;

  logic [p_mul_stages-1:0] stg_val;
  x2w_t                    stg_data [p_mul_stages];
  x2w_t                    in_data;
  logic                    advance;

  // Chain moves when the last stage is empty or accepted
  assign advance     = ~stg_val[p_mul_stages-1] | x2w_rdy;
  assign d2x_mul_rdy = advance;

  always_comb begin
    in_data       = '0;
    in_data.seq   = d2x_mul.seq;
    in_data.pdst  = d2x_mul.pdst;
    in_data.wen   = d2x_mul.wen;
    in_data.waddr = d2x_mul.waddr;
    // Low 32 bits of the product
    in_data.wdata = d2x_mul.op_a * d2x_mul.op_b;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stg_val <= '0;
    end else if (advance) begin
      stg_val[0] <= d2x_mul_val;
      for (int i = 1; i < p_mul_stages; i++) begin
        stg_val[i] <= stg_val[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      stg_data[0] <= in_data;
      for (int i = 1; i < p_mul_stages; i++) begin
        stg_data[i] <= stg_data[i-1];
      end
    end
  end

  assign x2w_mul     = stg_data[p_mul_stages-1];
  assign x2w_mul_val = stg_val[p_mul_stages-1];

endmodule

// ==== hw/writeback_commit_unit.sv ====
// Blimp writeback-commit unit
// Arbitrates the execute pipes, broadcasts each completion, tracks
// in-flight instructions in a ROB indexed by sequence number and
// commits the head in program order, one per cycle
`timescale 1ns/100ps

module writeback_commit_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blimp_pkg::d2x_t      d2x_issue,
  input  logic                 d2x_issue_val,
  input  blimp_pkg::x2w_t      x2w_alu,
  input  logic                 x2w_alu_val,
  output logic                 x2w_alu_rdy,
  input  blimp_pkg::x2w_t      x2w_mul,
  input  logic                 x2w_mul_val,
  output logic                 x2w_mul_rdy,
  output blimp_pkg::complete_t complete,
  output blimp_pkg::commit_t   commit
);
  import blimp_pkg::*;

  localparam int depth = 1 << p_seq_num_bits;

  // ROB storage
  addr_t                    rob_pc    [depth];
  areg_t                    rob_waddr [depth];
  word_t                    rob_wdata [depth];
  logic [preg_max_bits-1:0] rob_pold  [depth];
  logic [depth-1:0]         rob_wen;
  logic [depth-1:0]         rob_done;

  x2w_t                      win;
  logic                      win_val;
  logic [p_seq_num_bits-1:0] win_idx;
  logic [p_seq_num_bits-1:0] iss_idx;
  logic [p_seq_num_bits-1:0] head;

  // ---------------------------------------------------------------------
  // Writeback arbiter, multiplier first
  // ---------------------------------------------------------------------
  assign x2w_mul_rdy = 1'b1;
  assign x2w_alu_rdy = ~x2w_mul_val;
  assign win_val     = x2w_mul_val | x2w_alu_val;
  assign win         = x2w_mul_val ? x2w_mul : x2w_alu;
  assign win_idx     = win.seq[p_seq_num_bits-1:0];
  assign iss_idx     = d2x_issue.seq[p_seq_num_bits-1:0];

  // Broadcast only results that land in a register
  assign complete.val   = win_val & win.wen;
  assign complete.seq   = win.seq;
  assign complete.pdst  = win.pdst;
  assign complete.wdata = win.wdata;

  // Payload written at issue and completion
  always_ff @(posedge clk) begin
    if (d2x_issue_val) begin
      rob_pc[iss_idx]    <= d2x_issue.pc;
      rob_waddr[iss_idx] <= d2x_issue.waddr;
      rob_pold[iss_idx]  <= d2x_issue.pold;
      rob_wen[iss_idx]   <= d2x_issue.wen;
    end
    if (win_val) rob_wdata[win_idx] <= win.wdata;
  end

  // ---------------------------------------------------------------------
  // Done bits and in-order commit
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_done <= '0;
      head     <= '0;
      commit   <= '0;
    end else begin
      if (d2x_issue_val) rob_done[iss_idx] <= 1'b0;
      if (win_val) rob_done[win_idx] <= 1'b1;
      // Head retires once its done bit is visible
      if (rob_done[head]) begin
        commit.val       <= 1'b1;
        commit.seq       <= seq_max_bits'(head);
        commit.pc        <= rob_pc[head];
        commit.waddr     <= rob_waddr[head];
        commit.wdata     <= rob_wdata[head];
        commit.wen       <= rob_wen[head];
        commit.pold      <= rob_pold[head];
        rob_done[head]   <= 1'b0;
        head             <= head + 1'b1;
      end else begin
        commit.val <= 1'b0;
      end
    end
  end

  // Each in-flight entry completes exactly once
  a_no_double_done: assert property (@(posedge clk) disable iff (!rst_n)
    win_val |-> !rob_done[win_idx]);

  // Sequence numbers from issue stay within the ROB index range
  a_seq_range: assert property (@(posedge clk) disable iff (!rst_n)
    win_val |-> ((win.seq >> p_seq_num_bits) == '0));

endmodule

// ==== hw/blimp_core.sv ====
// Blimp core top level
// Fetch, decode-issue, ALU and multiplier pipes and writeback-commit,
// with each commit published on the instruction trace port
`timescale 1ns/100ps

module blimp_core #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_num_phys_regs = 40,
  parameter int p_mul_stages    = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output blimp_pkg::mem_req_t  imem_req,
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  input  blimp_pkg::mem_resp_t imem_resp,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  output blimp_pkg::trace_t    trace,
  output logic                 trace_val
);
  import blimp_pkg::*;

  f2d_t      f2d;
  logic      f2d_val, f2d_rdy;
  d2x_t      d2x_alu, d2x_mul;
  logic      d2x_alu_val, d2x_mul_val, alu_rdy, mul_rdy, d2x_issue_val;
  x2w_t      x2w_alu, x2w_mul;
  logic      x2w_alu_val, x2w_mul_val, x2w_alu_rdy, x2w_mul_rdy;
  complete_t complete;
  commit_t   commit;

  // Issue valids already include pipe readiness
  assign d2x_issue_val = d2x_alu_val | d2x_mul_val;

  // Trace straight from the commit pulse
  assign trace_val   = commit.val;
  assign trace.pc    = commit.pc;
  assign trace.waddr = commit.waddr;
  assign trace.wdata = commit.wdata;
  assign trace.wen   = commit.wen;

  fetch_unit fu (
    .clk, .rst_n, .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy, .f2d, .f2d_val, .f2d_rdy
  );

  decode_issue_unit #(
    .p_seq_num_bits  (p_seq_num_bits),
    .p_num_phys_regs (p_num_phys_regs)
  ) diu (
    .clk, .rst_n, .f2d, .f2d_val, .f2d_rdy,
    .d2x_alu, .d2x_alu_val, .alu_rdy, .d2x_mul, .d2x_mul_val, .mul_rdy,
    .complete, .commit
  );

  alu_unit alu_xu (
    .clk, .rst_n, .d2x_alu, .d2x_alu_val, .d2x_alu_rdy (alu_rdy),
    .x2w_alu, .x2w_alu_val, .x2w_rdy (x2w_alu_rdy)
  );

  pipelined_multiplier #(
    .p_mul_stages (p_mul_stages)
  ) mul_xu (
    .clk, .rst_n, .d2x_mul, .d2x_mul_val, .d2x_mul_rdy (mul_rdy),
    .x2w_mul, .x2w_mul_val, .x2w_rdy (x2w_mul_rdy)
  );

  // Both issue structs carry the same payload
  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) wcu (
    .clk, .rst_n, .d2x_issue (d2x_alu), .d2x_issue_val,
    .x2w_alu, .x2w_alu_val, .x2w_alu_rdy, .x2w_mul, .x2w_mul_val, .x2w_mul_rdy,
    .complete, .commit
  );

endmodule

// ==== verif/blimp_core_tb.sv ====
// Blimp core testbench
// Random add, addi and mul program from an LFSR, a stalling instruction
// memory model, a golden ISA model stepped on each commit, assertion
// checks on the trace port and a watchdog
`timescale 1ns/100ps

module blimp_core_tb;
  import blimp_pkg::*;

  localparam int          num_insts    = 200;
  localparam int          reset_cycles = 16;
  localparam int          rob_depth    = 8;
  // 40 cycles per instruction is far above the worst stall pattern
  localparam int          wd_cycles    = reset_cycles + num_insts * 40;
  localparam logic [31:0] lfsr_seed    = 32'h0ab6_bb6f;
  localparam logic [31:0] lfsr_taps    = 32'hd000_0001;

  logic      clk = 1'b0;
  logic      rst_n;
  mem_req_t  imem_req;
  logic      imem_req_val;
  logic      imem_req_rdy;
  mem_resp_t imem_resp;
  logic      imem_resp_val;
  logic      imem_resp_rdy;
  trace_t    trace;
  logic      trace_val;

  logic [31:0] lfsr = lfsr_seed;
  word_t       imem [256];
  addr_t       req_q [$];
  addr_t       next_req_addr = '0;
  logic        resp_fired = 1'b0;
  logic        drive_en = 1'b0;

  // Golden architectural state
  word_t gold_rf [32] = '{default: '0};
  addr_t exp_pc = '0;
  word_t g_inst, g_a, g_b, g_result;
  areg_t g_rd;
  logic  g_wen, g_is_mul, g_is_addi;

  int n_fetched = 0;
  int n_commits = 0;
  int n_alu = 0;
  int n_mul = 0;
  int n_x0 = 0;
  int peak = 0;
  int errs [6];

  blimp_core DUT (
    .clk, .rst_n, .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy, .trace, .trace_val
  );

  always #20 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Registers limited to x0..x7 for dense dependencies
  task automatic fill_imem();
    logic [31:0] r;
    for (int i = 0; i < 256; i++) begin
      r = next_bits(23);
      case (r[22:21])
        2'd0:    imem[i] = {7'b0000000, 2'b00, r[14:12], 2'b00, r[17:15], 3'b000,
                            2'b00, r[20:18], 7'b0110011};
        2'd1:    imem[i] = {r[11:0], 2'b00, r[17:15], 3'b000,
                            2'b00, r[20:18], 7'b0010011};
        // Half of the program is mul
        default: imem[i] = {7'b0000001, 2'b00, r[14:12], 2'b00, r[17:15], 3'b000,
                            2'b00, r[20:18], 7'b0110011};
      endcase
    end
  endtask

  // ---------------------------------------------------------------------
  // Instruction memory model
  // ---------------------------------------------------------------------
  // Transfers observed on the rising edge
  always @(posedge clk) begin
    resp_fired = imem_resp_val && imem_resp_rdy;
    drive_en   = rst_n;
    if (rst_n) begin
      if (imem_req_val && imem_req_rdy) begin
        req_q.push_back(imem_req.addr);
        next_req_addr <= next_req_addr + 32'd4;
      end
      if (resp_fired) begin
        void'(req_q.pop_front());
        n_fetched <= n_fetched + 1;
      end
      if (n_fetched - n_commits > peak) peak <= n_fetched - n_commits;
    end
  end

  // Random stalls on both channels, response held until taken
  always @(negedge clk) begin
    logic [31:0] r;
    if (drive_en) begin
      r = next_bits(2);
      imem_req_rdy = (r[1:0] != 2'b00);
      if (!imem_resp_val || resp_fired) begin
        if (req_q.size() != 0) begin
          r              = next_bits(2);
          imem_resp_val  = (r[1:0] != 2'b00);
          imem_resp.inst = imem[req_q[0][9:2]];
        end else begin
          imem_resp_val = 1'b0;
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Golden ISA model
  // ---------------------------------------------------------------------
  always_comb begin
    g_inst    = imem[exp_pc[9:2]];
    g_is_addi = (g_inst[6:0] == 7'b0010011);
    g_is_mul  = (g_inst[6:0] == 7'b0110011) && (g_inst[31:25] == 7'b0000001);
    g_rd      = g_inst[11:7];
    g_wen     = (g_rd != 5'd0);
    g_a       = gold_rf[g_inst[19:15]];
    g_b       = g_is_addi ? {{20{g_inst[31]}}, g_inst[31:20]} : gold_rf[g_inst[24:20]];
    // Low half of the product by truncation
    g_result  = g_is_mul ? g_a * g_b : g_a + g_b;
  end

  always @(posedge clk) begin
    if (rst_n && trace_val) begin
      if (g_wen) gold_rf[g_rd] <= g_result;
      exp_pc    <= exp_pc + 32'd4;
      n_commits <= n_commits + 1;
      if (!g_wen) n_x0 <= n_x0 + 1;
      else if (g_is_mul) n_mul <= n_mul + 1;
      else n_alu <= n_alu + 1;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!imem_req_val && !trace_val))
  else begin
    errs[0]++;
    $display("%0d ns: fetch request or commit seen while in reset", $time);
  end

  a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (imem_req_val && imem_req_rdy) |-> (imem_req.addr == next_req_addr))
  else begin
    errs[1]++;
    $display("mismatch at %0d ns: fetch address expected %h got %h", $time,
             $sampled(next_req_addr), $sampled(imem_req.addr));
  end

  a_commit_pc: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.pc == exp_pc))
  else begin
    errs[1]++;
    $display("mismatch at %0d ns: commit pc expected %h got %h", $time,
             $sampled(exp_pc), $sampled(trace.pc));
  end

  a_alu_value: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_val && g_wen && !g_is_mul) |-> (trace.wdata == g_result))
  else begin
    errs[2]++;
    $display("mismatch at %0d ns: add result at pc %h expected %h got %h", $time,
             $sampled(exp_pc), $sampled(g_result), $sampled(trace.wdata));
  end

  a_mul_value: assert property (@(posedge clk) disable iff (!rst_n)
    (trace_val && g_wen && g_is_mul) |-> (trace.wdata == g_result))
  else begin
    errs[3]++;
    $display("mismatch at %0d ns: mul result at pc %h expected %h got %h", $time,
             $sampled(exp_pc), $sampled(g_result), $sampled(trace.wdata));
  end

  // wen low exactly for x0 destinations
  a_wen: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.wen == g_wen))
  else begin
    errs[4]++;
    $display("mismatch at %0d ns: wen at pc %h expected %0b got %0b", $time,
             $sampled(exp_pc), $sampled(g_wen), $sampled(trace.wen));
  end

  // Architectural destination from the instruction word
  a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (trace.waddr == g_rd))
  else begin
    errs[4]++;
    $display("mismatch at %0d ns: waddr at pc %h expected %0d got %0d", $time,
             $sampled(exp_pc), $sampled(g_rd), $sampled(trace.waddr));
  end

  a_commit_after_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |-> (n_commits < n_fetched))
  else begin
    errs[5]++;
    $display("%0d ns: commit without a fetched instruction", $time);
  end

  // ROB plus the fetch buffer plus one commit in transit
  a_in_flight_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (n_fetched - n_commits) <= rob_depth + 2)
  else begin
    errs[5]++;
    $display("%0d ns: more instructions in flight than the core can hold", $time);
  end

  // ---------------------------------------------------------------------
  // Watchdog and run control
  // ---------------------------------------------------------------------
  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog: commits stalled with %0d of %0d instructions committed",
             n_commits, num_insts);
    $display("Something failed");
    $finish;
  end

  initial begin
    int total;
    int failed;
    rst_n          = 1'b0;
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp.inst = '0;
    fill_imem();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait (n_commits > 0);
    $display("test 1 reset_quiet: first commit at %0d ns, %0d errors", $time, errs[0]);
    wait (n_commits == num_insts);
    repeat (2) @(posedge clk);
    $display("test 2 commit_order: %0d commits checked, %0d errors", n_commits, errs[1]);
    $display("test 3 alu_results: %0d add and addi checked, %0d errors", n_alu, errs[2]);
    $display("test 4 mul_results: %0d mul checked, %0d errors", n_mul, errs[3]);
    $display("test 5 x0_writes: %0d x0 writes checked, %0d errors", n_x0, errs[4]);
    $display("test 6 drain_under_stalls: %0d fetched, peak %0d in flight, %0d errors",
             n_fetched, peak, errs[5]);
    total  = 0;
    failed = 0;
    for (int i = 0; i < 6; i++) begin
      total += errs[i];
      if (errs[i] != 0) failed++;
    end
    $display("summary: 6 tests, %0d failed, %0d errors", failed, total);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/blimp_pkg.sv
hw/fetch_unit.sv
hw/decode_issue_unit.sv
hw/alu_unit.sv
hw/pipelined_multiplier.sv
hw/writeback_commit_unit.sv
hw/blimp_core.sv
verif/blimp_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the blimp core testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := blimp_core_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
